// File: de_cfg_pkg.sv
package de_cfg_pkg;

	// Drawing opcodes
	// Codes outside this list are carried through as is
	typedef enum logic [3:0] {
		op_noop   = 4'd0,
		op_bitblt = 4'd1,
		op_line   = 4'd2,
		op_rect   = 4'd3,
		op_fill   = 4'd4
	} de_opc_e;

	// Pixel size in buf_ctrl[8:7], both odd codes select 16 bits
	typedef enum logic [1:0] {
		psize_8   = 2'd0,
		psize_16  = 2'd1,
		psize_32  = 2'd2,
		psize_16b = 2'd3
	} de_psize_e;

	typedef struct packed {
		logic [12:0] buf_ctrl;
		logic [31:0] sorg;
		logic [31:0] dorg;
		logic [11:0] sptch;
		logic [11:0] dptch;
		de_opc_e     opc;
		logic [3:0]  rop;
		logic [4:0]  style;
		logic        nlst;
		logic [1:0]  apat;
		logic [2:0]  clp;
		logic [31:0] fore;
		logic [31:0] back;
		logic [3:0]  mask;
		logic [23:0] de_key;
		logic [15:0] alpha;
		logic [17:0] acntrl;
		logic [1:0]  bc_lvl;
	} de_regs_t;

	// Host register map, word index
	localparam logic [3:0] addr_buf_ctrl = 4'd0;
	localparam logic [3:0] addr_sorg     = 4'd1;
	localparam logic [3:0] addr_dorg     = 4'd2;
	localparam logic [3:0] addr_pitch    = 4'd3;
	localparam logic [3:0] addr_fore     = 4'd4;
	localparam logic [3:0] addr_back     = 4'd5;
	localparam logic [3:0] addr_key      = 4'd6;
	localparam logic [3:0] addr_alpha    = 4'd7;
	localparam logic [3:0] addr_acntrl   = 4'd8;
	localparam logic [3:0] addr_cmd      = 4'd9;

endpackage

// File: de_bus_pkg.sv
package de_bus_pkg;

	// One host register write
	typedef struct packed {
		logic [3:0]  addr;
		logic [31:0] data;
	} host_wr_t;

	// Command packet handed to the drawing pipeline
	// fore and back are already replicated to 32 bits,
	// buf_ctrl carries the bit 3 fix-up
	typedef struct packed {
		de_cfg_pkg::de_regs_t regs;
	} de_cmd_t;

endpackage

// File: de_host_regs.sv
`timescale 1ns/1ns

module de_host_regs (
	input  logic                 de_clk,
	input  logic                 de_rstn,
	input  logic                 host_valid,
	input  de_bus_pkg::host_wr_t host_wr,
	output logic                 host_ready,
	input  logic                 cmd_busy,
	output de_cfg_pkg::de_regs_t s1_regs,
	output logic                 load_actvn
);

	import de_cfg_pkg::*;
	import de_bus_pkg::*;

	de_regs_t    s1_q;
	logic        wr_en;
	logic        cmd_wr;
	logic [31:0] wdata;
	de_opc_e     wr_opc;

	// Only the command word waits for stage 2
	always_comb begin
		host_ready = !((host_wr.addr == addr_cmd) && cmd_busy);
	end

	assign wr_en  = host_valid && host_ready;
	assign cmd_wr = wr_en && (host_wr.addr == addr_cmd);
	assign wdata  = host_wr.data;
	assign wr_opc = de_opc_e'(wdata[3:0]);

	// Stage-1 register file, one group per address
	always_ff @(posedge de_clk or negedge de_rstn) begin
		if (!de_rstn) begin
			s1_q <= '0;
		end else if (wr_en) begin
			case (host_wr.addr)
				addr_buf_ctrl: begin
					s1_q.buf_ctrl <= wdata[12:0];
				end
				addr_sorg: begin
					s1_q.sorg <= wdata;
				end
				addr_dorg: begin
					s1_q.dorg <= wdata;
				end
				addr_pitch: begin
					s1_q.sptch <= wdata[11:0];
					s1_q.dptch <= wdata[27:16];
				end
				addr_fore: begin
					s1_q.fore <= wdata;
				end
				addr_back: begin
					s1_q.back <= wdata;
				end
				addr_key: begin
					s1_q.de_key <= wdata[23:0];
					s1_q.mask   <= wdata[27:24];
				end
				addr_alpha: begin
					s1_q.alpha <= wdata[15:0];
				end
				addr_acntrl: begin
					s1_q.acntrl <= wdata[17:0];
				end
				addr_cmd: begin
					s1_q.opc    <= wr_opc;
					s1_q.rop    <= wdata[7:4];
					s1_q.style  <= wdata[12:8];
					s1_q.nlst   <= wdata[13];
					s1_q.apat   <= wdata[15:14];
					s1_q.clp    <= wdata[18:16];
					s1_q.bc_lvl <= wdata[21:20];
				end
				default: begin
					// Unmapped addresses are dropped
				end
			endcase
		end
	end

	// Activation strobe lands one cycle after the command word,
	// so stage 2 copies the freshly written fields
	always_ff @(posedge de_clk or negedge de_rstn) begin
		if (!de_rstn) begin
			load_actvn <= 1'b1;
		end else begin
			load_actvn <= !(cmd_wr && (wr_opc != op_noop));
		end
	end

	assign s1_regs = s1_q;

endmodule

// File: de_cmd_stage.sv
`timescale 1ns/1ns

module de_cmd_stage (
	input  logic                 de_clk,
	input  logic                 de_rstn,
	input  logic                 load_actvn,
	input  logic                 cmdcpyclr,
	input  de_cfg_pkg::de_regs_t s1_regs,
	output de_cfg_pkg::de_regs_t s2_regs,
	output logic                 cmd_busy
);

	import de_cfg_pkg::*;

	de_regs_t    s2_q;
	de_psize_e   psize;
	logic [31:0] fore_rep;
	logic [31:0] back_rep;
	logic [12:0] bc_fix;

	// Pixel size comes from the stage-1 buffer control being copied
	assign psize = de_psize_e'(s1_regs.buf_ctrl[8:7]);

	// Fill the 32-bit colors with copies of one pixel
	always_comb begin
		case (psize)
			psize_8: begin
				fore_rep = {4{s1_regs.fore[7:0]}};
				back_rep = {4{s1_regs.back[7:0]}};
			end
			psize_16, psize_16b: begin
				fore_rep = {2{s1_regs.fore[15:0]}};
				back_rep = {2{s1_regs.back[15:0]}};
			end
			default: begin
				fore_rep = s1_regs.fore;
				back_rep = s1_regs.back;
			end
		endcase
	end

	// Stage-2 set
	// The opcode clear is written last so it wins over a load
	always_ff @(posedge de_clk or negedge de_rstn) begin
		if (!de_rstn) begin
			s2_q <= '0;
		end else begin
			if (!load_actvn) begin
				s2_q      <= s1_regs;
				s2_q.fore <= fore_rep;
				s2_q.back <= back_rep;
			end
			if (cmdcpyclr) begin
				s2_q.opc <= op_noop;
			end
		end
	end

	// Bit 3 is forced when bits 2 and 0 are both set
	assign bc_fix = {
		s2_q.buf_ctrl[12:4],
		s2_q.buf_ctrl[3] | (s2_q.buf_ctrl[2] & s2_q.buf_ctrl[0]),
		s2_q.buf_ctrl[2:0]
	};

	always_comb begin
		s2_regs          = s2_q;
		s2_regs.buf_ctrl = bc_fix;
	end

	// A load already in flight also counts as busy, otherwise a
	// second command word could overwrite stage 2 before it issues
	assign cmd_busy = (s2_q.opc != op_noop) || !load_actvn;

endmodule

// File: de_cmd_issue.sv
`timescale 1ns/1ns

module de_cmd_issue (
	input  de_cfg_pkg::de_regs_t s2_regs,
	output logic                 cmd_valid,
	input  logic                 cmd_ready,
	output de_bus_pkg::de_cmd_t  cmd,
	output logic                 cmdcpyclr
);

	import de_cfg_pkg::*;
	import de_bus_pkg::*;

	logic pending;
	logic accept;

	// Stage 2 holds a command whenever its opcode is live
	assign pending = (s2_regs.opc != op_noop);

	// Packet follows stage 2 directly, steady while it is held
	always_comb begin
		cmd      = '0;
		cmd.regs = s2_regs;
	end

	assign cmd_valid = pending;

	// Handshake completes in the same cycle it is seen
	assign accept = pending && cmd_ready;

	// Opcode clear for stage 2, taken at the next edge
	assign cmdcpyclr = accept;

endmodule

// File: de_top.sv
`timescale 1ns/1ns

module de_top (
	input  logic                 de_clk,
	input  logic                 de_rstn,
	input  logic                 host_valid,
	input  de_bus_pkg::host_wr_t host_wr,
	output logic                 host_ready,
	output logic                 cmd_valid,
	input  logic                 cmd_ready,
	output de_bus_pkg::de_cmd_t  cmd
);

	import de_cfg_pkg::*;

	de_regs_t s1_regs;
	de_regs_t s2_regs;
	logic     load_actvn;
	logic     cmdcpyclr;
	logic     cmd_busy;

	// Host side and stage-1 registers
	de_host_regs u_host_regs (
		.de_clk     (de_clk),
		.de_rstn    (de_rstn),
		.host_valid (host_valid),
		.host_wr    (host_wr),
		.host_ready (host_ready),
		.cmd_busy   (cmd_busy),
		.s1_regs    (s1_regs),
		.load_actvn (load_actvn)
	);

	de_cmd_stage u_cmd_stage (
		.de_clk     (de_clk),
		.de_rstn    (de_rstn),
		.load_actvn (load_actvn),
		.cmdcpyclr  (cmdcpyclr),
		.s1_regs    (s1_regs),
		.s2_regs    (s2_regs),
		.cmd_busy   (cmd_busy)
	);

	// Pipeline side
	de_cmd_issue u_cmd_issue (
		.s2_regs   (s2_regs),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd       (cmd),
		.cmdcpyclr (cmdcpyclr)
	);

endmodule

// File: tb_de_asserts.sv
`timescale 1ns/1ns

module tb_de_asserts (
	input logic                 de_clk,
	input logic                 de_rstn,
	input logic                 host_valid,
	input de_bus_pkg::host_wr_t host_wr,
	input logic                 host_ready,
	input logic                 cmd_valid,
	input logic                 cmd_ready,
	input de_bus_pkg::de_cmd_t  cmd,
	input logic                 load_actvn
);

	import de_cfg_pkg::*;

	int   fail_count = 0;
	logic cmd_hit;
	logic go_idle;
	logic noop_idle;

	assign cmd_hit   = host_valid && host_ready && (host_wr.addr == addr_cmd);
	assign go_idle   = cmd_hit && (host_wr.data[3:0] != 4'd0) && !cmd_valid;
	assign noop_idle = cmd_hit && (host_wr.data[3:0] == 4'd0) && !cmd_valid && load_actvn;

	// Activation leaves one quiet cycle before the packet
	activation_gap: assert property (@(posedge de_clk) disable iff (!de_rstn)
		$past(go_idle) |-> !cmd_valid)
	else begin
		fail_count++;
		$error("cmd_valid rose one cycle after the command write");
	end

	activation_rise: assert property (@(posedge de_clk) disable iff (!de_rstn)
		$past(go_idle, 2) |-> cmd_valid)
	else begin
		fail_count++;
		$error("cmd_valid missing two cycles after the command write");
	end

	hold_on_stall: assert property (@(posedge de_clk) disable iff (!de_rstn)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
	else begin
		fail_count++;
		$error("packet changed or dropped while the pipeline stalled");
	end

	cmd_write_stall: assert property (@(posedge de_clk) disable iff (!de_rstn)
		host_valid && (host_wr.addr == addr_cmd) && cmd_valid |-> !host_ready)
	else begin
		fail_count++;
		$error("command write accepted while stage 2 is busy");
	end

	clear_after_accept: assert property (@(posedge de_clk) disable iff (!de_rstn)
		cmd_valid && cmd_ready && load_actvn |=> !cmd_valid)
	else begin
		fail_count++;
		$error("cmd_valid still high after the handshake");
	end

	// A noop command word must never start anything
	noop_stays_idle: assert property (@(posedge de_clk) disable iff (!de_rstn)
		$past(noop_idle) |-> load_actvn && !cmd_valid)
	else begin
		fail_count++;
		$error("noop command write fired the activation strobe");
	end

endmodule

bind de_top tb_de_asserts u_asserts (
	.de_clk     (de_clk),
	.de_rstn    (de_rstn),
	.host_valid (host_valid),
	.host_wr    (host_wr),
	.host_ready (host_ready),
	.cmd_valid  (cmd_valid),
	.cmd_ready  (cmd_ready),
	.cmd        (cmd),
	.load_actvn (load_actvn)
);

// File: tb_de_top.sv
`timescale 1ns/1ns

module tb_de_top;

	import de_cfg_pkg::*;
	import de_bus_pkg::*;

	localparam int num_cmds    = 40;
	localparam int cycle_limit = num_cmds * 30 + 200;

	logic     de_clk;
	logic     de_rstn;
	logic     host_valid;
	host_wr_t host_wr;
	logic     host_ready;
	logic     cmd_valid;
	logic     cmd_ready;
	de_cmd_t  cmd;

	integer     seed;
	integer     rdy_seed;
	logic [1:0] ready_mode;
	int         cycle_count;
	de_regs_t   s1_model;
	de_cmd_t    exp_q[$];

	de_top uut (
		.de_clk     (de_clk),
		.de_rstn    (de_rstn),
		.host_valid (host_valid),
		.host_wr    (host_wr),
		.host_ready (host_ready),
		.cmd_valid  (cmd_valid),
		.cmd_ready  (cmd_ready),
		.cmd        (cmd)
	);

	always #5 de_clk = ~de_clk;

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got == exp) else
			fail_stop($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	// Stage-1 image, decoded straight from the register map
	function automatic de_regs_t apply_write(input de_regs_t r, input logic [3:0] addr,
			input logic [31:0] d);
		de_regs_t n;
		n = r;
		case (addr)
			4'd0: n.buf_ctrl = d[12:0];
			4'd1: n.sorg = d;
			4'd2: n.dorg = d;
			4'd3: begin
				n.sptch = d[11:0];
				n.dptch = d[27:16];
			end
			4'd4: n.fore = d;
			4'd5: n.back = d;
			4'd6: begin
				n.de_key = d[23:0];
				n.mask   = d[27:24];
			end
			4'd7: n.alpha = d[15:0];
			4'd8: n.acntrl = d[17:0];
			4'd9: begin
				n.opc    = de_opc_e'(d[3:0]);
				n.rop    = d[7:4];
				n.style  = d[12:8];
				n.nlst   = d[13];
				n.apat   = d[15:14];
				n.clp    = d[18:16];
				n.bc_lvl = d[21:20];
			end
			default: n = r;
		endcase
		return n;
	endfunction

	// Packet as the pipeline should see it after activation
	function automatic de_regs_t expected_packet(input de_regs_t s1);
		de_regs_t e;
		e = s1;
		case (s1.buf_ctrl[8:7])
			2'd0: begin
				e.fore = {4{s1.fore[7:0]}};
				e.back = {4{s1.back[7:0]}};
			end
			2'd2: begin
				e.fore = s1.fore;
				e.back = s1.back;
			end
			default: begin
				e.fore = {2{s1.fore[15:0]}};
				e.back = {2{s1.back[15:0]}};
			end
		endcase
		e.buf_ctrl[3] = s1.buf_ctrl[3] | (s1.buf_ctrl[2] & s1.buf_ctrl[0]);
		return e;
	endfunction

	task automatic host_write(input logic [3:0] addr, input logic [31:0] data);
		logic accepted;
		host_valid   <= 1'b1;
		host_wr.addr <= addr;
		host_wr.data <= data;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge de_clk);
			accepted = host_ready;
			@(posedge de_clk);
		end
		host_valid <= 1'b0;
	endtask

	// Fills every mapped register, pokes one unmapped address, then starts
	task automatic send_command(input logic [3:0] opc_code, input logic [1:0] psize,
			input logic force_fix);
		logic [31:0] bc;
		logic [31:0] cw;
		bc = $random(seed);
		bc[8:7] = psize;
		if (force_fix) begin
			bc[3] = 1'b0;
			bc[2] = 1'b1;
			bc[0] = 1'b1;
		end
		host_write(addr_buf_ctrl, bc);
		host_write(addr_sorg, $random(seed));
		host_write(addr_dorg, $random(seed));
		host_write(addr_pitch, $random(seed));
		host_write(addr_fore, $random(seed));
		host_write(addr_back, $random(seed));
		host_write(addr_key, $random(seed));
		host_write(addr_alpha, $random(seed));
		host_write(addr_acntrl, $random(seed));
		host_write(4'd10 + 4'($random(seed) & 3), $random(seed));
		cw = $random(seed);
		cw[3:0] = opc_code;
		host_write(addr_cmd, cw);
	endtask

	task automatic wait_idle();
		@(negedge de_clk);
		while (cmd_valid || (exp_q.size() != 0)) begin
			@(negedge de_clk);
		end
		@(posedge de_clk);
	endtask

	// 0 random, 1 held low, 2 held high
	always @(posedge de_clk) begin
		case (ready_mode)
			2'd0: cmd_ready <= (($random(rdy_seed) % 3) != 0);
			2'd1: cmd_ready <= 1'b0;
			default: cmd_ready <= 1'b1;
		endcase
	end

	always @(posedge de_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			fail_stop($sformatf("timeout: run still busy after %0d cycles", cycle_limit));
		end
	end

	// Inputs are steady at the falling edge, so sample everything here
	always @(negedge de_clk) begin
		de_cmd_t exp_pkt;
		if (uut.u_asserts.fail_count != 0) begin
			fail_stop("a concurrent assertion failed, see the error above");
		end else if (de_rstn) begin
			if (host_valid && host_ready) begin
				s1_model = apply_write(s1_model, host_wr.addr, host_wr.data);
				if ((host_wr.addr == addr_cmd) && (host_wr.data[3:0] != 4'd0)) begin
					exp_pkt.regs = expected_packet(s1_model);
					exp_q.push_back(exp_pkt);
				end
			end
			if (cmd_valid && cmd_ready) begin
				if (exp_q.size() == 0) begin
					fail_stop("packet issued while no command was expected");
				end else begin
					exp_pkt = exp_q.pop_front();
					check_field("cmd.fore", cmd.regs.fore, exp_pkt.regs.fore);
					check_field("cmd.back", cmd.regs.back, exp_pkt.regs.back);
					check_field("cmd.buf_ctrl", 32'(cmd.regs.buf_ctrl),
						32'(exp_pkt.regs.buf_ctrl));
					check_field("cmd.opc", 32'(cmd.regs.opc), 32'(exp_pkt.regs.opc));
					assert (cmd == exp_pkt) else
						fail_stop($sformatf("mismatch at %0t: cmd got %h expected %h",
							$time, cmd, exp_pkt));
				end
			end
		end
	end

	initial begin
		logic [31:0] noop_word;
		de_clk      = 1'b0;
		de_rstn     = 1'b0;
		host_valid  = 1'b0;
		host_wr     = '0;
		cmd_ready   = 1'b0;
		ready_mode  = 2'd0;
		cycle_count = 0;
		s1_model    = '0;
		seed        = 32'he8d6_7c9f;
		rdy_seed    = seed ^ 32'h0000_ffff;

		repeat (10) @(posedge de_clk);
		de_rstn <= 1'b1;
		@(negedge de_clk);
		assert (cmd_valid == 1'b0) else
			fail_stop($sformatf("mismatch at %0t: cmd_valid got %b expected 0",
				$time, cmd_valid));
		assert (host_ready == 1'b1) else
			fail_stop($sformatf("mismatch at %0t: host_ready got %b expected 1",
				$time, host_ready));
		@(posedge de_clk);

		// Every pixel size with the bit 3 fix-up pattern
		for (int i = 0; i < 4; i++) begin
			send_command(4'(i + 1), 2'(i), 1'b1);
		end

		// A noop command word on an idle stage
		wait_idle();
		noop_word = $random(seed);
		noop_word[3:0] = 4'd0;
		host_write(addr_cmd, noop_word);
		repeat (4) @(posedge de_clk);

		// Pipeline stalled while the next command is assembled
		ready_mode <= 2'd1;
		send_command(op_rect, 2'd2, 1'b0);
		fork
			begin
				repeat (16) @(posedge de_clk);
				ready_mode <= 2'd0;
			end
			send_command(op_line, 2'd1, 1'b0);
		join

		repeat (num_cmds - 6) begin
			send_command(4'd1 + 4'($random(seed) & 7), 2'($random(seed)),
				1'($random(seed)));
		end

		wait_idle();
		repeat (4) @(posedge de_clk);
		if ((uut.u_asserts.fail_count == 0) && (exp_q.size() == 0)) begin
			$display("Regression passed");
			$finish;
		end else begin
			fail_stop("run ended with checks still open");
		end
	end

endmodule

// File: flist.f
de_cfg_pkg.sv
de_bus_pkg.sv
de_host_regs.sv
de_cmd_stage.sv
de_cmd_issue.sv
de_top.sv
tb_de_asserts.sv
tb_de_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the command front end regression with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module tb_de_top -f flist.f -o sim_de \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

# Let the testbench see every assertion error instead of stopping at the first
./obj_dir/sim_de +verilator+error+limit+100 > sim.log 2>&1 && sim_status=0 || sim_status=1
cat sim.log

grep -q "Regression failed" sim.log && { echo "FAIL"; exit 1; }
[ "$sim_status" -eq 0 ] && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }
